// File: adc_serial_reader.sv
//--------------------------------------------------------------------------
// serial ADC reader
// starts a conversion per frame, waits on busy, clocks out two data lanes
// and publishes all eight offset corrected channels at once
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module adc_serial_reader (
	input  logic              clk,
	input  logic              rst,
	input  logic              adc_tick,
	input  logic              frame_strobe,
	input  logic              busy,
	input  logic              db7,          // lane 0, channels 0..3
	input  logic              db8,          // lane 1, channels 4..7
	output logic              conv,
	output logic              rdclk,
	output synth_pkg::sample_t channels [synth_pkg::adc_channels],
	output logic              channels_valid
);

	localparam int shift_bits = synth_pkg::adc_slots * synth_pkg::sample_w;

	typedef enum logic [2:0] {
		st_idle,
		st_convert,
		st_wait_busy,
		st_shift,
		st_publish
	} state_t;

	state_t                 state;
	logic [5:0]             bit_cnt;             // bits taken per lane
	logic [shift_bits-1:0]  raw [synth_pkg::adc_lanes];

	// raw capture, msb of first channel ends up on top
	always_ff @(posedge clk) begin
		if (state == st_shift && adc_tick && !rdclk) begin
			raw[0] <= {raw[0][shift_bits-2:0], db7};
			raw[1] <= {raw[1][shift_bits-2:0], db8};
		end
	end

	//--------------------------------------------------------------------------
	// capture FSM
	//--------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state          <= st_idle;
			conv           <= 1'b1;               // inactive high
			rdclk          <= 1'b1;
			bit_cnt        <= '0;
			channels_valid <= 1'b0;
			for (int c = 0; c < synth_pkg::adc_channels; c++)
				channels[c] <= '0;
		end else begin
			channels_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (frame_strobe) begin           // strobes mid capture are dropped
						conv  <= 1'b0;
						state <= st_convert;
					end
				end
				st_convert: begin
					if (adc_tick) begin
						conv  <= 1'b1;                  // rising edge starts conversion
						state <= st_wait_busy;
					end
				end
				st_wait_busy: begin
					if (adc_tick && !busy) begin
						rdclk   <= 1'b0;
						bit_cnt <= '0;
						state   <= st_shift;
					end
				end
				st_shift: begin
					if (adc_tick) begin
						if (!rdclk) begin
							rdclk   <= 1'b1;              // data sampled on this edge
							bit_cnt <= bit_cnt + 6'd1;
							if (bit_cnt == 6'(shift_bits - 1))
								state <= st_publish;
						end else begin
							rdclk <= 1'b0;
						end
					end
				end
				st_publish: begin
					for (int c = 0; c < synth_pkg::adc_channels; c++)
						channels[c] <= raw[c / synth_pkg::adc_slots]
							[shift_bits - 1 - (c % synth_pkg::adc_slots) * synth_pkg::sample_w
							-: synth_pkg::sample_w]
							+ ((c == synth_pkg::ch_gate) ? synth_pkg::adc_offset_main
							                             : synth_pkg::adc_offset_aux);
					channels_valid <= 1'b1;
					state          <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: gate_envelope.sv
//--------------------------------------------------------------------------
// gate envelope
// rising gate reloads the peak, then a linear decay down to the floor
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module gate_envelope (
	input  logic               clk,
	input  logic               rst,
	input  logic               channels_valid,
	input  logic               gate,
	input  synth_pkg::sample_t decay_time,
	output synth_pkg::sample_t envelope
);

	logic               gate_q;                  // gate at last capture
	synth_pkg::sample_t div_cnt;                 // clocks until next step
	logic               retrig;

	// edge only, a held gate does not restart the decay
	assign retrig = channels_valid && gate && !gate_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			gate_q <= 1'b0;
		else if (channels_valid)
			gate_q <= gate;
	end

	// decay rate divider
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			div_cnt <= '0;
		else if (div_cnt == '0)
			div_cnt <= decay_time >> 4;           // longer decay, slower steps
		else
			div_cnt <= div_cnt - 16'd1;
	end

	//--------------------------------------------------------------------------
	// envelope level
	//--------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			envelope <= '0;
		end else if (retrig) begin
			envelope <= synth_pkg::env_peak;
		end else if (div_cnt == '0 && envelope > synth_pkg::env_floor) begin
			envelope <= envelope - 16'd1;         // one step per divider wrap
		end
	end

endmodule

// File: i2s_serializer.sv
//--------------------------------------------------------------------------
// I2S serializer
// latches left and right per frame, shifts both out msb first
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module i2s_serializer (
	input  logic               clk,
	input  logic               rst,
	input  logic               bit_tick,     // half a bck period
	input  logic               frame_strobe,
	input  synth_pkg::sample_t left,
	input  synth_pkg::sample_t right,
	output logic               bck,
	output logic               lrck,
	output logic               din
);

	synth_pkg::sample_t left_q;
	synth_pkg::sample_t right_q;
	synth_pkg::sample_t word_now;
	logic [5:0]         slot;                    // next half bit position
	logic [5:0]         slot_now;

	// frame strobe restarts the slot count and brings in new words
	always_comb begin
		slot_now = frame_strobe ? 6'd0 : slot;
		if (frame_strobe)
			word_now = left;                      // latch happens this clk
		else if (slot[5])
			word_now = right_q;
		else
			word_now = left_q;
	end

	always_ff @(posedge clk) begin
		if (frame_strobe) begin
			left_q  <= left;
			right_q <= right;
		end
	end

	//--------------------------------------------------------------------------
	// bit clock, word select and data
	//--------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			slot <= '0;
			bck  <= 1'b0;
			lrck <= 1'b0;
			din  <= 1'b0;
		end else if (bit_tick) begin
			slot <= slot_now + 6'd1;
			bck  <= slot_now[0];                  // high on odd ticks
			lrck <= slot_now[5];                  // left half first
			if (!slot_now[0])
				din <= word_now[4'd15 - slot_now[4:1]]; // only with bck low
		end
	end

endmodule

// File: sim.f
synth_pkg.sv
voice_sequencer.sv
adc_serial_reader.sv
gate_envelope.sv
supersaw_osc.sv
vca_mixer.sv
i2s_serializer.sv
synth_voice_top.sv
synth_voice_assert.sv
tb_synth_voice.sv

// File: supersaw_osc.sv
//--------------------------------------------------------------------------
// supersaw oscillator
// eight detuned ramps stepped per frame, top bits summed into one sample
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module supersaw_osc (
	input  logic               clk,
	input  logic               rst,
	input  logic               frame_strobe,
	input  synth_pkg::sample_t pitch,
	output synth_pkg::sample_t sample
);

	localparam int n_ramps = $size(synth_pkg::saw_detune);
	localparam int phase_w = $bits(synth_pkg::phase_t);

	synth_pkg::phase_t  ramp [n_ramps];
	synth_pkg::phase_t  pitch_inc;
	synth_pkg::sample_t ramp_sum;
	logic               strobe_q;                // sum one clk after the step

	assign pitch_inc = synth_pkg::phase_t'(pitch) << 8;

	// sum wraps at 16 bits
	always_comb begin
		ramp_sum = '0;
		for (int i = 0; i < n_ramps; i++)
			ramp_sum = ramp_sum
				+ synth_pkg::sample_t'(ramp[i][phase_w-1 -: synth_pkg::saw_top_bits]);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < n_ramps; i++)
				ramp[i] <= '0;
			strobe_q <= 1'b0;
			sample   <= '0;
		end else begin
			strobe_q <= frame_strobe;
			if (frame_strobe) begin
				for (int i = 0; i < n_ramps; i++)
					ramp[i] <= ramp[i] + pitch_inc + synth_pkg::saw_detune[i];
			end
			if (strobe_q)
				sample <= ramp_sum;                  // ramps already stepped
		end
	end

endmodule

// File: synth_pkg.sv
//--------------------------------------------------------------------------
// synth voice shared definitions
// sample and phase types, ADC channel map, offsets and envelope limits
//--------------------------------------------------------------------------
package synth_pkg;

	localparam int sample_w = 16;                // audio and ADC word width

	typedef logic [sample_w-1:0] sample_t;       // unsigned sample word
	typedef logic [31:0]         phase_t;        // supersaw accumulator

	// serial ADC layout
	localparam int adc_lanes    = 2;             // db7 and db8
	localparam int adc_slots    = 4;             // channels per lane
	localparam int adc_channels = adc_lanes * adc_slots;

	// channel roles
	localparam int ch_gate  = 0;                 // monitor, msb is the gate
	localparam int ch_decay = 1;
	localparam int ch_pitch = 4;

	// offsets added to raw conversions
	localparam sample_t adc_offset_main = 16'h8000;
	localparam sample_t adc_offset_aux  = 16'h5000;

	// decay envelope limits
	localparam sample_t env_peak  = 16'h7ffc;    // start after a gate edge
	localparam sample_t env_floor = 16'd1;       // decay stops here

	// per ramp increments, spread for the detuned chorus
	localparam phase_t saw_detune [8] = '{
		32'd78855, 32'd98851, 32'd118853, 32'd138857,
		32'd148853, 32'd158855, 32'd168857, 32'd178851
	};

	localparam int saw_top_bits = 13;            // bits kept from each ramp

endpackage

// File: synth_voice_assert.sv
//--------------------------------------------------------------------------
// synth voice protocol assertions
// conv width, rdclk idle during busy, lrck timing and bck count per frame
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module synth_voice_assert (
	input logic clk,
	input logic rst,
	input logic adc_tick,
	input logic frame_strobe,
	input logic conv,
	input logic rdclk,
	input logic busy,
	input logic bck,
	input logic lrck
);

	logic       bck_q;
	logic [5:0] bck_rises;                       // rises since last strobe
	logic       framed;                          // one full frame seen

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bck_q     <= 1'b0;
			bck_rises <= '0;
			framed    <= 1'b0;
		end else begin
			bck_q <= bck;
			if (frame_strobe) begin
				bck_rises <= '0;
				framed    <= 1'b1;
			end else if (bck && !bck_q) begin
				bck_rises <= bck_rises + 6'd1;
			end
		end
	end

	// conv released at the first adc_tick
	assert property (@(posedge clk) disable iff (rst) (!conv && adc_tick) |=> conv)
		else $error("conv low longer than one adc_tick period");

	assert property (@(posedge clk) disable iff (rst) busy |-> rdclk)
		else $error("rdclk toggled while busy");

	assert property (@(posedge clk) disable iff (rst) (lrck != $past(lrck)) |-> !bck)
		else $error("lrck changed while bck high");

	assert property (@(posedge clk) disable iff (rst) (frame_strobe && framed)
		|-> (bck_rises == 6'd32))
		else $error("frame without 32 bck rising edges");

endmodule

bind synth_voice_top synth_voice_assert i_assert (
	.clk (clk), .rst (rst), .adc_tick (adc_tick), .frame_strobe (frame_strobe),
	.conv (conv), .rdclk (rdclk), .busy (busy), .bck (bck), .lrck (lrck)
);

// File: synth_voice_top.sv
//--------------------------------------------------------------------------
// synth voice top level
// serial ADC in, envelope shaped supersaw, I2S DAC out
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module synth_voice_top #(
	parameter int adc_div_bits = 2,
	parameter int dac_div_bits = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic busy,
	input  logic db7,
	input  logic db8,
	output logic conv,
	output logic rdclk,
	output logic bck,
	output logic lrck,
	output logic din
);

	logic               adc_tick;
	logic               bit_tick;
	logic               frame_strobe;
	logic               channels_valid;
	synth_pkg::sample_t channels [synth_pkg::adc_channels];
	synth_pkg::sample_t envelope;
	synth_pkg::sample_t osc_sample;
	synth_pkg::sample_t voice;                   // right word
	synth_pkg::sample_t monitor;                 // left word

	voice_sequencer #(
		.adc_div_bits (adc_div_bits),
		.dac_div_bits (dac_div_bits)
	) i_seq (
		.clk          (clk),
		.rst          (rst),
		.adc_tick     (adc_tick),
		.bit_tick     (bit_tick),
		.frame_strobe (frame_strobe)
	);

	adc_serial_reader i_adc (
		.clk (clk), .rst (rst), .adc_tick (adc_tick), .frame_strobe (frame_strobe),
		.busy (busy), .db7 (db7), .db8 (db8), .conv (conv), .rdclk (rdclk),
		.channels (channels), .channels_valid (channels_valid)
	);

	// gate is the msb of the monitor channel
	gate_envelope i_env (
		.clk (clk), .rst (rst), .channels_valid (channels_valid),
		.gate (channels[synth_pkg::ch_gate][synth_pkg::sample_w-1]),
		.decay_time (channels[synth_pkg::ch_decay]), .envelope (envelope)
	);

	supersaw_osc i_osc (
		.clk (clk), .rst (rst), .frame_strobe (frame_strobe),
		.pitch (channels[synth_pkg::ch_pitch]), .sample (osc_sample)
	);

	vca_mixer i_vca (
		.clk (clk), .rst (rst), .envelope (envelope), .osc (osc_sample),
		.monitor_in (channels[synth_pkg::ch_gate]), .voice (voice), .monitor (monitor)
	);

	i2s_serializer i_i2s (
		.clk (clk), .rst (rst), .bit_tick (bit_tick), .frame_strobe (frame_strobe),
		.left (monitor), .right (voice), .bck (bck), .lrck (lrck), .din (din)
	);

endmodule

// File: tb_synth_voice.sv
//--------------------------------------------------------------------------
// synth voice testbench
// serial ADC model, I2S receiver and directed tests for the voice top
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_synth_voice;

	localparam int adc_div_bits = 2;
	localparam int dac_div_bits = 4;
	localparam int frame_clks   = 64 << dac_div_bits;   // clk per I2S frame

	logic clk;
	logic rst;
	logic busy;
	logic db7;
	logic db8;
	logic conv;
	logic rdclk;
	logic bck;
	logic lrck;
	logic din;

	integer             seed = 32'hbcbe_0ba7;
	int                 error_count = 0;
	synth_pkg::sample_t raw_words [synth_pkg::adc_channels];   // ADC model contents

	// ADC model state
	logic [63:0] lane0;
	logic [63:0] lane1;
	logic        conv_q = 1'b1;
	logic        rdclk_q = 1'b1;
	int          busy_left = 0;
	int          bit_idx = 0;
	int          captures = 0;
	int          conv_pulses = 0;
	int          rdclk_pulses = 0;

	// I2S receiver state
	synth_pkg::sample_t rx_word;
	synth_pkg::sample_t last_left;
	synth_pkg::sample_t last_right;
	logic               rx_side;
	logic               left_pending = 1'b0;
	int                 rx_cnt = 0;
	int                 frame_count = 0;       // bumps on each right word

	synth_voice_top #(
		.adc_div_bits (adc_div_bits),
		.dac_div_bits (dac_div_bits)
	) i_dut (
		.clk (clk), .rst (rst), .busy (busy), .db7 (db7), .db8 (db8),
		.conv (conv), .rdclk (rdclk), .bck (bck), .lrck (lrck), .din (din)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;                // 40 ns period
	end

	//--------------------------------------------------------------------------
	// checks and waits
	//--------------------------------------------------------------------------
	task automatic stop_on_error(input string what);
		error_count++;
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_sample(input string test, input synth_pkg::sample_t expected,
		input synth_pkg::sample_t actual);
		if (actual !== expected)
			stop_on_error($sformatf("Error: %s expected %h actual %h", test, expected, actual));
	endtask

	task automatic check_bit(input string test, input logic expected, input logic actual);
		if (actual !== expected)
			stop_on_error($sformatf("Error: %s expected %b actual %b", test, expected, actual));
	endtask

	// unipolar monitor word, written from the channel 0 rule
	function automatic synth_pkg::sample_t to_unipolar(input synth_pkg::sample_t word);
		logic [14:0] low;
		low = 15'(32768 - word[14:0]);         // 15 bit two's complement
		if (word[15])
			return {1'b1, low};
		return 16'h8000 - word;
	endfunction

	task automatic next_frame();
		int start;
		int waited;
		start  = frame_count;
		waited = 0;
		while (frame_count == start) begin
			@(negedge clk);
			waited++;
			if (waited > 2 * frame_clks)
				stop_on_error("timeout, no I2S frame arrived");
		end
	endtask

	task automatic wait_nonzero_right(input string test, input int max_frames);
		int n;
		n = 1;
		next_frame();
		while (last_right == '0) begin
			if (n >= max_frames)
				stop_on_error($sformatf("%s: right word stayed zero for %0d frames", test, n));
			next_frame();
			n++;
		end
	endtask

	// a run of zero right words marks the envelope at its floor
	task automatic wait_quiet_right(input string test, input int run, input int max_frames);
		int zeros;
		int n;
		zeros = 0;
		n     = 0;
		while (zeros < run) begin
			next_frame();
			n++;
			zeros = (last_right == '0) ? zeros + 1 : 0;
			if (n >= max_frames && zeros < run)
				stop_on_error($sformatf("%s: right words not silent after %0d frames", test, n));
		end
	endtask

	//--------------------------------------------------------------------------
	// ADC model, busy after conv, one bit per falling rdclk
	//--------------------------------------------------------------------------
	always @(negedge clk) begin
		if (!rst) begin
			if (conv_q && !conv)
				conv_pulses++;
			if (!conv_q && conv) begin           // conversion starts
				if (captures > 0 && bit_idx != 64)
					stop_on_error($sformatf("capture ended after %0d rdclk pulses", bit_idx));
				lane0     = {raw_words[0], raw_words[1], raw_words[2], raw_words[3]};
				lane1     = {raw_words[4], raw_words[5], raw_words[6], raw_words[7]};
				busy      = 1'b1;
				busy_left = 6;
				bit_idx   = 0;
				captures++;
			end else if (busy_left > 0) begin
				busy_left--;
				if (busy_left == 0)
					busy = 1'b0;
			end
			if (rdclk_q && !rdclk && bit_idx < 64) begin
				db7 = lane0[63 - bit_idx];           // msb first
				db8 = lane1[63 - bit_idx];
				bit_idx++;
			end
			if (!rdclk_q && rdclk)
				rdclk_pulses++;
		end
		conv_q  = conv;
		rdclk_q = rdclk;
	end

	// I2S receiver, left half then right half
	always @(posedge bck) begin
		if (rx_cnt == 0)
			rx_side = lrck;
		else if (lrck !== rx_side)
			stop_on_error($sformatf("word select changed after %0d bits", rx_cnt));
		rx_word = {rx_word[14:0], din};
		rx_cnt++;
		if (rx_cnt == 16) begin
			rx_cnt = 0;
			if (!rx_side) begin
				if (left_pending)
					stop_on_error("two left words without a right word between them");
				left_pending = 1'b1;
				last_left    = rx_word;
			end else begin
				if (!left_pending)
					stop_on_error("right word arrived before its left word");
				left_pending = 1'b0;
				last_right   = rx_word;
				frame_count++;
			end
		end
	end

	//--------------------------------------------------------------------------
	// directed tests
	//--------------------------------------------------------------------------
	task automatic test_reset();
		rst = 1'b1;
		repeat (8) @(negedge clk);
		check_bit("reset conv", 1'b1, conv);
		check_bit("reset rdclk", 1'b1, rdclk);
		check_bit("reset bck", 1'b0, bck);
		check_bit("reset lrck", 1'b0, lrck);
		check_bit("reset din", 1'b0, din);
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_bit("after reset conv", 1'b1, conv);
		check_bit("after reset rdclk", 1'b1, rdclk);
		check_bit("after reset bck", 1'b0, bck);
		check_bit("after reset lrck", 1'b0, lrck);
		check_bit("after reset din", 1'b0, din);
	endtask

	task automatic test_silence();
		repeat (6) begin
			next_frame();
			check_sample("silence right word", 16'h0000, last_right);
		end
	endtask

	task automatic test_framing();
		int c0;
		int r0;
		next_frame();
		c0 = conv_pulses;
		r0 = rdclk_pulses;
		repeat (4) next_frame();
		check_sample("framing conv pulses", 16'd4, 16'(conv_pulses - c0));
		check_sample("framing rdclk pulses", 16'd256, 16'(rdclk_pulses - r0));
	endtask

	task automatic test_monitor();
		synth_pkg::sample_t raw;
		synth_pkg::sample_t expected;
		int                 n;
		repeat (5) begin
			raw                          = 16'($random(seed));
			raw[15]                      = 1'b1;    // gate stays clear after offset
			raw_words[synth_pkg::ch_gate] = raw;
			expected = to_unipolar(raw + synth_pkg::adc_offset_main);
			n        = 0;
			next_frame();
			while (last_left !== expected && n < 6) begin
				next_frame();
				n++;
			end
			check_sample("monitor left word", expected, last_left);
			check_sample("monitor right word", 16'h0000, last_right);
		end
	endtask

	task automatic test_trigger_decay();
		synth_pkg::sample_t raw;
		raw_words[synth_pkg::ch_decay] = 16'hb008;  // decay 8, one step per clk
		raw_words[synth_pkg::ch_pitch] = 16'h0400;
		raw                            = 16'($random(seed));
		raw[15]                        = 1'b0;      // gate high
		raw_words[synth_pkg::ch_gate]  = raw;
		wait_nonzero_right("trigger", 6);
		// same capture feeds the left word, msb set branch
		check_sample("gate monitor left word",
			to_unipolar(raw + synth_pkg::adc_offset_main), last_left);
		wait_quiet_right("decay", 4, 80);
	endtask

	task automatic test_edge_only();
		repeat (6) begin
			next_frame();
			check_sample("held gate right word", 16'h0000, last_right);
		end
		raw_words[synth_pkg::ch_gate][15] = 1'b1;   // gate low
		repeat (3) begin
			next_frame();
			check_sample("gate low right word", 16'h0000, last_right);
		end
		raw_words[synth_pkg::ch_gate][15] = 1'b0;   // new rising edge
		wait_nonzero_right("retrigger", 6);
	endtask

	initial begin
		rst  = 1'b1;
		busy = 1'b0;
		db7  = 1'b0;
		db8  = 1'b0;
		for (int i = 0; i < synth_pkg::adc_channels; i++)
			raw_words[i] = 16'($random(seed));
		raw_words[synth_pkg::ch_gate][15] = 1'b1;   // gate low from reset
		test_reset();
		test_silence();
		test_framing();
		test_monitor();
		test_trigger_decay();
		test_edge_only();
		if (error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: vca_mixer.sv
//--------------------------------------------------------------------------
// VCA and monitor conversion
// pipelined envelope times oscillator, plus bipolar to unipolar monitor
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module vca_mixer (
	input  logic               clk,
	input  logic               rst,
	input  synth_pkg::sample_t envelope,
	input  synth_pkg::sample_t osc,
	input  synth_pkg::sample_t monitor_in,
	output synth_pkg::sample_t voice,
	output synth_pkg::sample_t monitor
);

	logic [2*synth_pkg::sample_w-1:0] product;   // stage 1, full width

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			product <= '0;
			voice   <= '0;
			monitor <= '0;
		end else begin
			product <= envelope * osc;
			voice   <= product[2*synth_pkg::sample_w-1 -: synth_pkg::sample_w]; // stage 2
			if (monitor_in[synth_pkg::sample_w-1])
				monitor <= {1'b1, 15'(~monitor_in[14:0] + 15'd1)};
			else
				monitor <= 16'h8000 - monitor_in;   // from mid scale
		end
	end

endmodule

// File: voice_sequencer.sv
//--------------------------------------------------------------------------
// voice sequencer
// divides clk into the ADC tick, the DAC half-bit tick and the frame strobe
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module voice_sequencer #(
	parameter int adc_div_bits = 2,              // adc_tick every 2^n clk
	parameter int dac_div_bits = 4               // bit_tick every 2^n clk
) (
	input  logic clk,
	input  logic rst,
	output logic adc_tick,
	output logic bit_tick,
	output logic frame_strobe
);

	logic [adc_div_bits-1:0] adc_cnt;
	logic [dac_div_bits-1:0] dac_cnt;
	logic [5:0]              bit_pos;            // half-bit slot within frame

	// ADC timing
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			adc_cnt  <= '0;
			adc_tick <= 1'b0;
		end else begin
			adc_cnt  <= adc_cnt + 1'b1;
			adc_tick <= (adc_cnt == '1);            // one clk wide
		end
	end

	//--------------------------------------------------------------------------
	// DAC timing and frame position
	//--------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dac_cnt      <= '0;
			bit_pos      <= '0;
			bit_tick     <= 1'b0;
			frame_strobe <= 1'b0;
		end else begin
			dac_cnt      <= dac_cnt + 1'b1;
			bit_tick     <= 1'b0;
			frame_strobe <= 1'b0;
			if (dac_cnt == '1) begin
				bit_tick     <= 1'b1;
				frame_strobe <= (bit_pos == 6'd0);   // first half bit of frame
				bit_pos      <= bit_pos + 6'd1;      // wraps after 64
			end
		end
	end

endmodule
